//--- verilog/tl_cache_pkg.sv
package tl_cache_pkg;

    parameter int WORD_SIZE        = 32;
    parameter int DCACHE_BYTE_SIZE = 4;  // 16-byte lines
    parameter int DCACHE_TAG_SIZE  = WORD_SIZE - DCACHE_BYTE_SIZE;
    parameter int REG_SIZE         = 5;

    // Access width of a memop
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_size_e;

    typedef enum logic [1:0] {
        TL_IDLE,
        MISS_IN_FLIGHT,    // Store miss refilling in the background
        HAZARD_DC_MISS,
        HAZARD_SB_TROUBLE
    } tl_fsm_state_e;

    // Address seen as a raw word or as line tag plus byte offset
    typedef union packed {
        logic [WORD_SIZE-1:0] raw;
        struct packed {
            logic [DCACHE_TAG_SIZE-1:0]  tag;
            logic [DCACHE_BYTE_SIZE-1:0] offset;
        } line;
    } tl_addr_u;

endpackage : tl_cache_pkg

//--- verilog/dcache_tag.sv
module dcache_tag #(
    parameter int DCACHE_LINES = 4,
    localparam int IDX_W = (DCACHE_LINES > 1) ? $clog2(DCACHE_LINES) : 1
) (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    input  logic                                     req_i,
    input  logic [tl_cache_pkg::DCACHE_TAG_SIZE-1:0] tag_i,
    input  logic                                     fill_i,
    input  logic [tl_cache_pkg::DCACHE_TAG_SIZE-1:0] fill_tag_i,
    output logic                                     hit_o,
    output logic                                     miss_o,
    output logic [IDX_W-1:0]                         addr_index_o
);

    logic [tl_cache_pkg::DCACHE_TAG_SIZE-1:0] tags_q [DCACHE_LINES];
    logic [DCACHE_LINES-1:0] valid_q;
    logic [IDX_W-1:0]        victim_q;
    logic [IDX_W-1:0]        hit_idx;
    logic                    hit_any;
    logic                    fill_present;

    // Fully associative compare, all ways in parallel
    always_comb begin
        hit_any      = 1'b0;
        hit_idx      = '0;
        fill_present = 1'b0;
        for (int i = 0; i < DCACHE_LINES; i++) begin
            if (valid_q[i] && tags_q[i] == tag_i) begin
                hit_any = 1'b1;
                hit_idx = IDX_W'(i);
            end
            if (valid_q[i] && tags_q[i] == fill_tag_i) fill_present = 1'b1;
        end
    end

    assign hit_o        = req_i & hit_any;
    assign miss_o       = req_i & ~hit_any;
    assign addr_index_o = hit_any ? hit_idx : victim_q;  // Victim way on a miss

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (fill_i) begin
            valid_q[victim_q] <= 1'b1;
            victim_q <= (victim_q == IDX_W'(DCACHE_LINES - 1)) ? '0 : victim_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) tags_q[victim_q] <= fill_tag_i;
    end

    // One refill per missing line, so a line is never cached twice
    a_no_dup_fill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill_i |-> !fill_present);

endmodule : dcache_tag

//--- verilog/store_buffer.sv
module store_buffer #(
    parameter int SB_DEPTH = 2
) (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  req_store_i,
    input  logic                                  req_load_i,
    input  tl_cache_pkg::tl_addr_u                addr_i,
    input  logic [tl_cache_pkg::WORD_SIZE-1:0]    data_i,
    input  tl_cache_pkg::memop_size_e             type_i,
    input  logic                                  flush_chance_i,
    input  logic                                  drain_gnt_i,
    input  logic                                  drain_done_i,
    output logic                                  hit_o,
    output logic                                  miss_o,
    output logic                                  trouble_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0]    data_o,
    output tl_cache_pkg::memop_size_e             type_o,
    output logic                                  drain_req_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0]    drain_addr_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0]    drain_data_o,
    output tl_cache_pkg::memop_size_e             drain_type_o
);

    localparam int PTR_W = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1;
    localparam int CNT_W = $clog2(SB_DEPTH + 1);
    localparam int OFS_HI = tl_cache_pkg::DCACHE_BYTE_SIZE - 1;

    tl_cache_pkg::tl_addr_u                addr_q [SB_DEPTH];
    logic [tl_cache_pkg::WORD_SIZE-1:0]    data_q [SB_DEPTH];
    tl_cache_pkg::memop_size_e             type_q [SB_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             push;
    logic             match_word;
    logic             match_part;

    // Walk oldest to youngest so the youngest match wins
    always_comb begin : lookup
        int idx;
        match_word = 1'b0;
        match_part = 1'b0;
        data_o     = '0;
        type_o     = tl_cache_pkg::WORD;
        for (int k = 0; k < SB_DEPTH; k++) begin
            idx = (int'(head_q) + k) % SB_DEPTH;
            if (k < int'(count_q) && addr_q[idx].line.tag == addr_i.line.tag &&
                addr_q[idx].line.offset[OFS_HI:2] == addr_i.line.offset[OFS_HI:2]) begin
                match_word = (type_q[idx] == tl_cache_pkg::WORD);
                match_part = (type_q[idx] != tl_cache_pkg::WORD);
                data_o     = data_q[idx];
                type_o     = type_q[idx];
            end
        end
    end

    assign full      = (count_q == CNT_W'(SB_DEPTH));
    assign hit_o     = req_load_i & match_word;
    assign miss_o    = req_load_i & ~match_word;
    assign trouble_o = (req_store_i & full) | (req_load_i & match_part);
    // No push while the stage is only offering a drain slot
    assign push      = req_store_i & ~trouble_o & ~flush_chance_i;

    // Keep requesting through a running grant
    assign drain_req_o  = (count_q != '0) & (flush_chance_i | drain_gnt_i);
    assign drain_addr_o = addr_q[head_q].raw;
    assign drain_data_o = data_q[head_q];
    assign drain_type_o = type_q[head_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) tail_q <= (tail_q == PTR_W'(SB_DEPTH - 1)) ? '0 : tail_q + 1'b1;
            if (drain_done_i) head_q <= (head_q == PTR_W'(SB_DEPTH - 1)) ? '0 : head_q + 1'b1;
            count_q <= count_q + CNT_W'(push) - CNT_W'(drain_done_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_q[tail_q] <= addr_i;
            data_q[tail_q] <= data_i;
            type_q[tail_q] <= type_i;
        end
    end

    // A drain only completes for a store that is still buffered
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        drain_done_i |-> count_q != '0);

endmodule : store_buffer

//--- verilog/mem_arbiter.sv
module mem_arbiter (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               refill_req_i,
    input  logic [tl_cache_pkg::WORD_SIZE-1:0] refill_addr_i,
    input  logic                               drain_req_i,
    input  logic [tl_cache_pkg::WORD_SIZE-1:0] drain_addr_i,
    input  logic [tl_cache_pkg::WORD_SIZE-1:0] drain_data_i,
    input  tl_cache_pkg::memop_size_e          drain_type_i,
    input  logic                               mem_rdy_i,
    output logic                               refill_gnt_o,
    output logic                               drain_gnt_o,
    output logic                               refill_done_o,
    output logic                               drain_done_o,
    output logic                               mem_req_o,
    output logic                               mem_we_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0] mem_addr_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0] mem_wdata_o,
    output tl_cache_pkg::memop_size_e          mem_type_o
);

    // Owner register; a running transfer is never cut off
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            refill_gnt_o <= 1'b0;
            drain_gnt_o  <= 1'b0;
        end else if (mem_req_o) begin
            if (mem_rdy_i) begin
                refill_gnt_o <= 1'b0;
                drain_gnt_o  <= 1'b0;
            end
        end else if (refill_req_i) begin
            refill_gnt_o <= 1'b1;  // Refill first
        end else if (drain_req_i) begin
            drain_gnt_o <= 1'b1;
        end
    end

    assign refill_done_o = refill_gnt_o & mem_rdy_i;
    assign drain_done_o  = drain_gnt_o & mem_rdy_i;

    assign mem_req_o   = refill_gnt_o | drain_gnt_o;
    assign mem_we_o    = drain_gnt_o;  // Reads are line refills
    assign mem_addr_o  = drain_gnt_o ? drain_addr_i : refill_addr_i;
    assign mem_wdata_o = drain_gnt_o ? drain_data_i : '0;
    assign mem_type_o  = drain_gnt_o ? drain_type_i : tl_cache_pkg::WORD;

    // Bus fields hold steady until mem_rdy_i ends the transfer
    a_bus_steady: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o && !mem_rdy_i |=> mem_req_o && $stable(mem_we_o) &&
        $stable(mem_addr_o) && $stable(mem_wdata_o) && $stable(mem_type_o));

endmodule : mem_arbiter

//--- verilog/tl_stage.sv
module tl_stage #(
    parameter int DCACHE_LINES = 4,
    localparam int IDX_W = (DCACHE_LINES > 1) ? $clog2(DCACHE_LINES) : 1
) (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    // EX side
    input  logic                                     memop_rd_i,
    input  logic                                     memop_wr_i,
    input  tl_cache_pkg::tl_addr_u                   addr_i,
    input  tl_cache_pkg::memop_size_e                memop_type_i,
    input  logic [tl_cache_pkg::REG_SIZE-1:0]        rf_waddr_i,
    // Tag array and store buffer
    input  logic                                     dc_hit_i,
    input  logic                                     dc_miss_i,
    input  logic [IDX_W-1:0]                         dc_index_i,
    input  logic                                     sb_hit_i,
    input  logic                                     sb_miss_i,
    input  logic                                     sb_trouble_i,
    input  logic [tl_cache_pkg::WORD_SIZE-1:0]       sb_data_i,
    input  tl_cache_pkg::memop_size_e                sb_type_i,
    input  logic                                     refill_done_i,
    output logic                                     req_o,
    output logic                                     sb_store_o,
    output logic                                     sb_load_o,
    output logic                                     flush_chance_o,
    output logic [tl_cache_pkg::DCACHE_TAG_SIZE-1:0] tag_o,
    output logic                                     refill_req_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0]       refill_addr_o,
    // MEM side
    output logic                                     memop_rd_o,
    output logic                                     memop_wr_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0]       addr_o,
    output tl_cache_pkg::memop_size_e                memop_type_o,
    output logic [tl_cache_pkg::REG_SIZE-1:0]        rf_waddr_o,
    output logic [IDX_W-1:0]                         addr_index_o,
    output logic                                     dc_hit_o,
    output logic                                     sb_hit_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0]       sb_data_o,
    output logic                                     stall_o
);

    tl_cache_pkg::tl_fsm_state_e state_q;
    tl_cache_pkg::tl_fsm_state_e state_d;
    logic [tl_cache_pkg::DCACHE_TAG_SIZE-1:0] inflight_q;
    logic same_line;
    logic hold;  // Stall for any reason other than store-buffer trouble

    assign same_line = (addr_i.line.tag == inflight_q);

    always_comb begin
        unique case (state_q)
            tl_cache_pkg::TL_IDLE:        hold = memop_rd_i & dc_miss_i & sb_miss_i;
            // Only a store or an SB-served load to the refilling line may pass
            tl_cache_pkg::MISS_IN_FLIGHT: hold = (memop_wr_i & dc_hit_i) |
                                                 (dc_miss_i & (~same_line | (memop_rd_i & sb_miss_i)));
            tl_cache_pkg::HAZARD_DC_MISS: hold = 1'b1;
            default:                      hold = 1'b0;
        endcase
    end

    assign stall_o = hold | sb_trouble_i | (state_q == tl_cache_pkg::HAZARD_SB_TROUBLE);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            tl_cache_pkg::TL_IDLE: begin
                if (sb_trouble_i)                 state_d = tl_cache_pkg::HAZARD_SB_TROUBLE;
                else if (memop_wr_i && dc_miss_i) state_d = tl_cache_pkg::MISS_IN_FLIGHT;
                else if (hold)                    state_d = tl_cache_pkg::HAZARD_DC_MISS;
            end
            tl_cache_pkg::MISS_IN_FLIGHT,
            tl_cache_pkg::HAZARD_DC_MISS: if (refill_done_i) state_d = tl_cache_pkg::TL_IDLE;
            default:                      if (!sb_trouble_i) state_d = tl_cache_pkg::TL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) state_q <= tl_cache_pkg::TL_IDLE;
        else          state_q <= state_d;
    end

    // Tag of the line being refilled
    always_ff @(posedge clk_i) begin
        if (state_q == tl_cache_pkg::TL_IDLE && (state_d == tl_cache_pkg::MISS_IN_FLIGHT ||
            state_d == tl_cache_pkg::HAZARD_DC_MISS))
            inflight_q <= addr_i.line.tag;
    end

    assign req_o          = memop_rd_i | memop_wr_i;
    assign sb_store_o     = memop_wr_i & ~hold;
    assign sb_load_o      = memop_rd_i;
    assign flush_chance_o = (state_q == tl_cache_pkg::TL_IDLE && !req_o) ||
                            state_q == tl_cache_pkg::HAZARD_SB_TROUBLE;
    assign tag_o          = inflight_q;
    assign refill_req_o   = (state_q == tl_cache_pkg::MISS_IN_FLIGHT) ||
                            (state_q == tl_cache_pkg::HAZARD_DC_MISS);
    assign refill_addr_o  = {inflight_q, {tl_cache_pkg::DCACHE_BYTE_SIZE{1'b0}}};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            memop_rd_o   <= 1'b0;
            memop_wr_o   <= 1'b0;
            addr_o       <= '0;
            memop_type_o <= tl_cache_pkg::BYTE;
            rf_waddr_o   <= '0;
            addr_index_o <= '0;
            dc_hit_o     <= 1'b0;
            sb_hit_o     <= 1'b0;
            sb_data_o    <= '0;
        end else if (!stall_o) begin
            memop_rd_o   <= memop_rd_i & ~sb_hit_i;  // Load already served by the SB
            memop_wr_o   <= memop_wr_i;
            addr_o       <= addr_i.raw;
            memop_type_o <= sb_hit_i ? sb_type_i : memop_type_i;
            rf_waddr_o   <= rf_waddr_i;
            addr_index_o <= dc_index_i;
            dc_hit_o     <= dc_hit_i;
            sb_hit_o     <= sb_hit_i;
            sb_data_o    <= sb_data_i;
        end else begin
            // Bubble to MEM
            memop_rd_o <= 1'b0;
            memop_wr_o <= 1'b0;
            dc_hit_o   <= 1'b0;
            sb_hit_o   <= 1'b0;
        end
    end

endmodule : tl_stage

//--- verilog/tl_cache_top.sv
module tl_cache_top #(
    parameter int DCACHE_LINES = 4,
    parameter int SB_DEPTH     = 2,
    localparam int IDX_W = (DCACHE_LINES > 1) ? $clog2(DCACHE_LINES) : 1
) (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               memop_rd_i,
    input  logic                               memop_wr_i,
    input  tl_cache_pkg::tl_addr_u             addr_i,
    input  tl_cache_pkg::memop_size_e          memop_type_i,
    input  logic [tl_cache_pkg::WORD_SIZE-1:0] st_data_i,
    input  logic [tl_cache_pkg::REG_SIZE-1:0]  rf_waddr_i,
    output logic                               memop_rd_o,
    output logic                               memop_wr_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0] addr_o,
    output tl_cache_pkg::memop_size_e          memop_type_o,
    output logic [tl_cache_pkg::REG_SIZE-1:0]  rf_waddr_o,
    output logic [IDX_W-1:0]                   addr_index_o,
    output logic                               dc_hit_o,
    output logic                               sb_hit_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0] sb_data_o,
    output logic                               stall_o,
    output logic                               mem_req_o,
    output logic                               mem_we_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0] mem_addr_o,
    output logic [tl_cache_pkg::WORD_SIZE-1:0] mem_wdata_o,
    output tl_cache_pkg::memop_size_e          mem_type_o,
    input  logic                               mem_rdy_i
);

    logic dc_req, dc_hit, dc_miss;
    logic [IDX_W-1:0] dc_index;
    logic [tl_cache_pkg::DCACHE_TAG_SIZE-1:0] fill_tag;
    logic sb_store, sb_load, sb_hit, sb_miss, sb_trouble, flush_chance;
    logic [tl_cache_pkg::WORD_SIZE-1:0] sb_data;
    tl_cache_pkg::memop_size_e sb_type;
    logic refill_req, refill_gnt, refill_done;
    logic [tl_cache_pkg::WORD_SIZE-1:0] refill_addr;
    logic drain_req, drain_gnt, drain_done;
    logic [tl_cache_pkg::WORD_SIZE-1:0] drain_addr, drain_data;
    tl_cache_pkg::memop_size_e drain_type;

    tl_stage #(
        .DCACHE_LINES (DCACHE_LINES)
    ) u_tl_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .memop_rd_i     (memop_rd_i),
        .memop_wr_i     (memop_wr_i),
        .addr_i         (addr_i),
        .memop_type_i   (memop_type_i),
        .rf_waddr_i     (rf_waddr_i),
        .dc_hit_i       (dc_hit),
        .dc_miss_i      (dc_miss),
        .dc_index_i     (dc_index),
        .sb_hit_i       (sb_hit),
        .sb_miss_i      (sb_miss),
        .sb_trouble_i   (sb_trouble),
        .sb_data_i      (sb_data),
        .sb_type_i      (sb_type),
        .refill_done_i  (refill_done),
        .req_o          (dc_req),
        .sb_store_o     (sb_store),
        .sb_load_o      (sb_load),
        .flush_chance_o (flush_chance),
        .tag_o          (fill_tag),
        .refill_req_o   (refill_req),
        .refill_addr_o  (refill_addr),
        .memop_rd_o     (memop_rd_o),
        .memop_wr_o     (memop_wr_o),
        .addr_o         (addr_o),
        .memop_type_o   (memop_type_o),
        .rf_waddr_o     (rf_waddr_o),
        .addr_index_o   (addr_index_o),
        .dc_hit_o       (dc_hit_o),
        .sb_hit_o       (sb_hit_o),
        .sb_data_o      (sb_data_o),
        .stall_o        (stall_o)
    );

    dcache_tag #(
        .DCACHE_LINES (DCACHE_LINES)
    ) u_dcache_tag (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (dc_req),
        .tag_i        (addr_i.line.tag),
        .fill_i       (refill_done),
        .fill_tag_i   (fill_tag),
        .hit_o        (dc_hit),
        .miss_o       (dc_miss),
        .addr_index_o (dc_index)
    );

    store_buffer #(
        .SB_DEPTH (SB_DEPTH)
    ) u_store_buffer (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_store_i    (sb_store),
        .req_load_i     (sb_load),
        .addr_i         (addr_i),
        .data_i         (st_data_i),
        .type_i         (memop_type_i),
        .flush_chance_i (flush_chance),
        .drain_gnt_i    (drain_gnt),
        .drain_done_i   (drain_done),
        .hit_o          (sb_hit),
        .miss_o         (sb_miss),
        .trouble_o      (sb_trouble),
        .data_o         (sb_data),
        .type_o         (sb_type),
        .drain_req_o    (drain_req),
        .drain_addr_o   (drain_addr),
        .drain_data_o   (drain_data),
        .drain_type_o   (drain_type)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .drain_req_i   (drain_req),
        .drain_addr_i  (drain_addr),
        .drain_data_i  (drain_data),
        .drain_type_i  (drain_type),
        .mem_rdy_i     (mem_rdy_i),
        .refill_gnt_o  (refill_gnt),
        .drain_gnt_o   (drain_gnt),
        .refill_done_o (refill_done),
        .drain_done_o  (drain_done),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_type_o    (mem_type_o)
    );

    // Refill is granted only while the stage is waiting on a line
    a_refill_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        refill_gnt |-> refill_req);

endmodule : tl_cache_top

//--- dv/tl_cache_tb.sv
module tl_cache_tb;

    localparam int LINES   = 4;
    localparam int DEPTH   = 2;
    localparam int TIMEOUT = 200;
    localparam int CYCLES  = 3000;

    logic clk_i;
    logic rst_n_i;
    logic memop_rd_i;
    logic memop_wr_i;
    tl_cache_pkg::tl_addr_u addr_i;
    tl_cache_pkg::memop_size_e memop_type_i;
    logic [31:0] st_data_i;
    logic [4:0] rf_waddr_i;
    logic mem_rdy_i;
    logic memop_rd_o;
    logic memop_wr_o;
    logic [31:0] addr_o;
    tl_cache_pkg::memop_size_e memop_type_o;
    logic [4:0] rf_waddr_o;
    logic [1:0] addr_index_o;
    logic dc_hit_o;
    logic sb_hit_o;
    logic [31:0] sb_data_o;
    logic stall_o;
    logic mem_req_o;
    logic mem_we_o;
    logic [31:0] mem_addr_o;
    logic [31:0] mem_wdata_o;
    tl_cache_pkg::memop_size_e mem_type_o;

    // Reference model state
    tl_cache_pkg::tl_fsm_state_e m_state;
    logic [27:0] m_tags [LINES];
    logic [LINES-1:0] m_valid;
    int m_victim;
    logic [27:0] m_inflight;
    int m_owner;  // 0 bus free, 1 refill, 2 drain
    logic [31:0] q_addr [$];
    logic [31:0] q_data [$];
    tl_cache_pkg::memop_size_e q_type [$];
    logic [31:0] exp_mem [logic [31:0]];
    logic [31:0] mem_model [logic [31:0]];

    // Expected MEM stage registers
    logic e_rd, e_wr, e_dc_hit, e_sb_hit;
    logic [31:0] e_addr, e_sb_data;
    tl_cache_pkg::memop_size_e e_type;
    logic [4:0] e_rf;
    int e_index;

    logic [31:0] lcg_state;
    logic exp_stall;
    bit held;
    int rdy_wait;
    int stall_run;
    int waited;

    tl_cache_top #(
        .DCACHE_LINES (LINES),
        .SB_DEPTH     (DEPTH)
    ) UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'b0, lcg_state[31:16]};  // Upper bits have the longer period
    endfunction

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_size(input string what, input tl_cache_pkg::memop_size_e got,
                              input tl_cache_pkg::memop_size_e exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
            stop_run();
        end
    endtask

    // Every MEM register cleared, no stall and an idle bus
    task automatic check_reset_state();
        check_flag("memop_rd_o", memop_rd_o, 1'b0);
        check_flag("memop_wr_o", memop_wr_o, 1'b0);
        check_word("addr_o", addr_o, '0);
        check_size("memop_type_o", memop_type_o, tl_cache_pkg::memop_size_e'(0));
        check_word("rf_waddr_o", 32'(rf_waddr_o), '0);
        check_word("addr_index_o", 32'(addr_index_o), '0);
        check_flag("dc_hit_o", dc_hit_o, 1'b0);
        check_flag("sb_hit_o", sb_hit_o, 1'b0);
        check_word("sb_data_o", sb_data_o, '0);
        check_flag("stall_o", stall_o, 1'b0);
        check_flag("mem_req_o", mem_req_o, 1'b0);
    endtask

    task automatic check_outputs();
        check_flag("memop_rd_o", memop_rd_o, e_rd);
        check_flag("memop_wr_o", memop_wr_o, e_wr);
        check_flag("dc_hit_o", dc_hit_o, e_dc_hit);
        check_flag("sb_hit_o", sb_hit_o, e_sb_hit);
        if (e_rd || e_wr || e_sb_hit) begin
            check_word("addr_o", addr_o, e_addr);
            check_size("memop_type_o", memop_type_o, e_type);
            check_word("rf_waddr_o", 32'(rf_waddr_o), 32'(e_rf));
            check_word("addr_index_o", 32'(addr_index_o), e_index);
        end
        if (e_sb_hit) check_word("sb_data_o", sb_data_o, e_sb_data);
        check_flag("mem_req_o", mem_req_o, m_owner != 0);
        if (m_owner == 1) begin
            check_flag("mem_we_o", mem_we_o, 1'b0);
            check_word("refill mem_addr_o", mem_addr_o, {m_inflight, 4'b0});
        end else if (m_owner == 2) begin
            // Oldest buffered store goes out first
            check_flag("mem_we_o", mem_we_o, 1'b1);
            check_word("drain mem_addr_o", mem_addr_o, q_addr[0]);
            check_word("drain mem_wdata_o", mem_wdata_o, q_data[0]);
            check_size("drain mem_type_o", mem_type_o, q_type[0]);
        end
    endtask

    task automatic respond();
        if (mem_rdy_i) begin
            mem_rdy_i = 1'b0;
        end else if (mem_req_o) begin
            if (rdy_wait == 0) rdy_wait = 1 + int'(lcg_next() % 4);
            rdy_wait--;
            if (rdy_wait == 0) begin
                mem_rdy_i = 1'b1;
                if (mem_we_o) mem_model[mem_addr_o] = mem_wdata_o;
            end
        end
    endtask

    task automatic pick_op(input bit allow_ops);
        int unsigned kind;
        int unsigned line;
        int unsigned word;
        int unsigned size;
        int unsigned bofs;
        kind = lcg_next() % 8;
        line = lcg_next() % 6;  // Six lines over four ways
        word = lcg_next() % 2;
        size = lcg_next() % 4;
        bofs = lcg_next() % 4;
        memop_rd_i   = allow_ops && kind >= 2 && kind <= 4;
        memop_wr_i   = allow_ops && kind >= 5;
        memop_type_i = (size == 0) ? tl_cache_pkg::BYTE :
                       (size == 1) ? tl_cache_pkg::HALF : tl_cache_pkg::WORD;
        if (size == 1) bofs = bofs & 2;
        if (size > 1) bofs = 0;
        addr_i.line.tag    = 28'h0001000 + 28'(line);
        addr_i.line.offset = {2'(word), 2'(bofs)};
        st_data_i  = lcg_next() ^ (lcg_next() << 16);
        rf_waddr_i = 5'(lcg_next());
    endtask

    task automatic model_cycle(output logic stall);
        logic any_op, hit, sb_word, sb_part, sb_hit, trouble, flush, hold, push;
        logic refill_done, drain_done, drain_req;
        logic [31:0] fwd_data;
        int way;
        tl_cache_pkg::tl_fsm_state_e nxt;
        any_op = memop_rd_i | memop_wr_i;
        hit = 1'b0;
        way = m_victim;
        for (int i = 0; i < LINES; i++) begin
            if (m_valid[i] && m_tags[i] == addr_i.line.tag) begin
                hit = 1'b1;
                way = i;
            end
        end
        sb_word = 1'b0;
        sb_part = 1'b0;
        fwd_data = '0;
        foreach (q_addr[k]) begin
            if (q_addr[k][31:2] == addr_i.raw[31:2]) begin  // Youngest match wins
                sb_word  = (q_type[k] == tl_cache_pkg::WORD);
                sb_part  = !sb_word;
                fwd_data = q_data[k];
            end
        end
        sb_hit  = memop_rd_i && sb_word;
        trouble = (memop_wr_i && q_addr.size() == DEPTH) || (memop_rd_i && sb_part);
        flush   = (m_state == tl_cache_pkg::TL_IDLE && !any_op) ||
                  m_state == tl_cache_pkg::HAZARD_SB_TROUBLE;
        case (m_state)
            tl_cache_pkg::TL_IDLE:        hold = memop_rd_i && !hit && !sb_hit;
            tl_cache_pkg::MISS_IN_FLIGHT: hold = (memop_wr_i && hit) || (any_op && !hit &&
                (addr_i.line.tag != m_inflight || (memop_rd_i && !sb_hit)));
            tl_cache_pkg::HAZARD_DC_MISS: hold = 1'b1;
            default:                      hold = 1'b0;
        endcase
        stall = hold || trouble || m_state == tl_cache_pkg::HAZARD_SB_TROUBLE;
        push  = memop_wr_i && !stall;
        refill_done = (m_owner == 1) && mem_rdy_i;
        drain_done  = (m_owner == 2) && mem_rdy_i;
        drain_req   = q_addr.size() != 0 && (flush || m_owner == 2);
        nxt = m_state;
        case (m_state)
            tl_cache_pkg::TL_IDLE: begin
                if (trouble) nxt = tl_cache_pkg::HAZARD_SB_TROUBLE;
                else if (memop_wr_i && !hit) nxt = tl_cache_pkg::MISS_IN_FLIGHT;
                else if (hold) nxt = tl_cache_pkg::HAZARD_DC_MISS;
            end
            tl_cache_pkg::MISS_IN_FLIGHT, tl_cache_pkg::HAZARD_DC_MISS: begin
                if (refill_done) nxt = tl_cache_pkg::TL_IDLE;
            end
            default: if (!trouble) nxt = tl_cache_pkg::TL_IDLE;
        endcase
        if (!stall) begin
            e_rd      = memop_rd_i && !sb_hit;
            e_wr      = memop_wr_i;
            e_addr    = addr_i.raw;
            e_type    = sb_hit ? tl_cache_pkg::WORD : memop_type_i;
            e_rf      = rf_waddr_i;
            e_index   = way;
            e_dc_hit  = any_op && hit;
            e_sb_hit  = sb_hit;
            e_sb_data = fwd_data;
        end else begin
            e_rd     = 1'b0;
            e_wr     = 1'b0;
            e_dc_hit = 1'b0;
            e_sb_hit = 1'b0;
        end
        if (refill_done) begin
            m_tags[m_victim] = m_inflight;
            m_valid[m_victim] = 1'b1;
            m_victim = (m_victim + 1) % LINES;
        end
        if (drain_done) begin
            void'(q_addr.pop_front());
            void'(q_data.pop_front());
            void'(q_type.pop_front());
        end
        if (push) begin
            q_addr.push_back(addr_i.raw);
            q_data.push_back(st_data_i);
            q_type.push_back(memop_type_i);
            exp_mem[addr_i.raw] = st_data_i;
        end
        if (m_state == tl_cache_pkg::TL_IDLE && nxt != tl_cache_pkg::TL_IDLE &&
            nxt != tl_cache_pkg::HAZARD_SB_TROUBLE) m_inflight = addr_i.line.tag;
        if (m_owner != 0) begin
            if (mem_rdy_i) m_owner = 0;
        end else if (m_state == tl_cache_pkg::MISS_IN_FLIGHT ||
                     m_state == tl_cache_pkg::HAZARD_DC_MISS) begin
            m_owner = 1;  // Refill wins the bus
        end else if (drain_req) begin
            m_owner = 2;
        end
        m_state = nxt;
    endtask

    task automatic run_cycle(input bit allow_ops);
        @(negedge clk_i);
        check_outputs();
        respond();
        if (!held) pick_op(allow_ops);  // EX holds a stalled op
        #1;
        model_cycle(exp_stall);
        check_flag("stall_o", stall_o, exp_stall);
        held = exp_stall;
        stall_run = exp_stall ? stall_run + 1 : 0;
        if (stall_run > TIMEOUT) begin
            $display("Timeout at %0t: stall_o stayed high for %0d cycles", $time, TIMEOUT);
            stop_run();
        end
    endtask

    initial begin
        lcg_state = 32'd38;
        rst_n_i = 1'b0;
        memop_rd_i = 1'b0;
        memop_wr_i = 1'b0;
        addr_i = '0;
        memop_type_i = tl_cache_pkg::WORD;
        st_data_i = '0;
        rf_waddr_i = '0;
        mem_rdy_i = 1'b0;
        m_state = tl_cache_pkg::TL_IDLE;
        m_valid = '0;
        m_victim = 0;
        m_inflight = '0;
        m_owner = 0;
        {e_rd, e_wr, e_dc_hit, e_sb_hit} = '0;
        e_addr = '0;
        e_sb_data = '0;
        e_type = tl_cache_pkg::BYTE;
        e_rf = '0;
        e_index = 0;
        held = 1'b0;
        rdy_wait = 0;
        stall_run = 0;
        repeat (3) @(negedge clk_i);
        check_reset_state();
        rst_n_i = 1'b1;
        for (int n = 0; n < CYCLES; n++) run_cycle(1'b1);
        // Idle until every store has reached memory
        waited = 0;
        while (q_addr.size() != 0 || m_owner != 0 || m_state != tl_cache_pkg::TL_IDLE) begin
            run_cycle(1'b0);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout at %0t: store buffer did not drain", $time);
                stop_run();
            end
        end
        @(negedge clk_i);
        check_outputs();  // Registers of the last modelled cycle
        check_word("memory word count", 32'(mem_model.size()), 32'(exp_mem.size()));
        foreach (exp_mem[a]) check_word("memory word", mem_model[a], exp_mem[a]);
        $display("Test completed successfully");
        $finish;
    end

endmodule : tl_cache_tb

//--- tl_cache.f
verilog/tl_cache_pkg.sv
verilog/dcache_tag.sv
verilog/store_buffer.sv
verilog/mem_arbiter.sv
verilog/tl_stage.sv
verilog/tl_cache_top.sv
dv/tl_cache_tb.sv

//--- Makefile
TOP = tl_cache_tb

all: run

build:
	verilator --binary --timing --assert -f tl_cache.f --top-module $(TOP) -o $(TOP) --Mdir obj_dir

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing -f tl_cache.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
